// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
LINT     = --lint-only --timing -Wall
TOP      = dcache_tb
RTL_TOP  = dcache
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/dcache.sv ====
// data cache top level with address split and store to controller wiring
`include "dcache_params.svh"

module dcache (
  input  logic              CLK,
  input  logic              nRST,
  // datapath side
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  logic              halt,
  input  dcache_pkg::word_t dmemaddr,
  input  dcache_pkg::word_t dmemstore,
  output logic              dhit,
  output logic              flushed,
  output dcache_pkg::word_t dmemload,
  // memory side
  output logic              dREN,
  output logic              dWEN,
  output dcache_pkg::word_t daddr,
  output dcache_pkg::word_t dstore,
  input  logic              dwait,
  input  dcache_pkg::word_t dload
);
  import dcache_pkg::*;

  tag_t      req_tag;
  set_idx_t  req_idx;
  word_sel_t req_wsel;

  logic     hit, blk_valid, blk_dirty;
  way_t     flush_way;
  tag_t     blk_tag;
  word_t    blk_data0, blk_data1;
  logic     flush_mode;
  set_idx_t flush_idx;
  logic     fill_en, fill_wsel, store_en, touch_en, inval_en;

  // tag | index | word select | byte offset
  assign req_tag  = dmemaddr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
  assign req_idx  = dmemaddr[`DCACHE_IDX_LSB +: `DCACHE_IDX_W];
  assign req_wsel = dmemaddr[`DCACHE_WSEL_BIT];

  dcache_store u_store (
    .CLK, .nRST, .req_tag, .req_idx, .req_wsel,
    .flush_mode, .flush_idx, .flush_way,
    .fill_en, .fill_wsel, .store_en, .touch_en, .inval_en,
    .fill_data (dload),
    .store_data(dmemstore),
    .hit,
    .hit_way   (),
    .hit_word  (dmemload),
    .victim_way(),
    .blk_valid, .blk_dirty, .blk_tag, .blk_data0, .blk_data1
  );

  dcache_ctrl u_ctrl (
    .CLK, .nRST, .dmemREN, .dmemWEN, .halt, .req_tag, .req_idx,
    .hit, .blk_valid, .blk_dirty, .blk_tag, .blk_data0, .blk_data1, .dwait,
    .dhit, .flushed, .flush_mode, .flush_idx, .flush_way,
    .fill_en, .fill_wsel, .store_en, .touch_en, .inval_en,
    .dREN, .dWEN, .daddr, .dstore
  );

endmodule

// ==== design/dcache_ctrl.sv ====
// data cache controller FSM for hits, write-back, fill and flush
module dcache_ctrl (
  input  logic                 CLK,
  input  logic                 nRST,
  // datapath requests
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  logic                 halt,
  input  dcache_pkg::tag_t     req_tag,
  input  dcache_pkg::set_idx_t req_idx,
  // store results
  input  logic                 hit,
  input  logic                 blk_valid,
  input  logic                 blk_dirty,
  input  dcache_pkg::tag_t     blk_tag,
  input  dcache_pkg::word_t    blk_data0,
  input  dcache_pkg::word_t    blk_data1,
  // memory stall
  input  logic                 dwait,
  // datapath status
  output logic                 dhit,
  output logic                 flushed,
  // store control
  output logic                 flush_mode,
  output dcache_pkg::set_idx_t flush_idx,
  output dcache_pkg::way_t     flush_way,
  output logic                 fill_en,
  output logic                 fill_wsel,
  output logic                 store_en,
  output logic                 touch_en,
  output logic                 inval_en,
  // memory port
  output logic                 dREN,
  output logic                 dWEN,
  output dcache_pkg::word_t    daddr,
  output dcache_pkg::word_t    dstore
);
  import dcache_pkg::*;

  cache_state_t state;
  cache_state_t state_nxt;
  set_idx_t     flush_idx_nxt;
  way_t         flush_way_nxt;

  logic     req;
  logic     need_wb;   // selected block must go back to memory
  logic     last_blk;  // final set of way 1
  set_idx_t wb_idx;
  set_idx_t step_idx;
  way_t     step_way;

  assign req     = dmemREN | dmemWEN;
  assign need_wb = blk_valid & blk_dirty;

  assign flush_mode = (state == FLUSH_SCAN) || (state == FLUSH_WB0) || (state == FLUSH_WB1);
  assign flushed    = (state == FLUSHED);

  // hits are answered combinationally from IDLE
  assign dhit     = (state == IDLE) && req && hit;
  assign touch_en = dhit;
  assign store_en = dhit && dmemWEN;

  // write-back set comes from the flush walk or the request
  assign wb_idx = flush_mode ? flush_idx : req_idx;

  // flush walk order: all sets of way 0, then way 1
  assign last_blk = (&flush_idx) & flush_way;
  assign step_idx = flush_idx + set_idx_t'(1);
  assign step_way = (&flush_idx) ? ~flush_way : flush_way;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      flush_idx <= '0;
      flush_way <= '0;
    end else begin
      state     <= state_nxt;
      flush_idx <= flush_idx_nxt;
      flush_way <= flush_way_nxt;
    end
  end

  always_comb begin
    state_nxt     = state;
    flush_idx_nxt = flush_idx;
    flush_way_nxt = flush_way;
    dREN          = 1'b0;
    dWEN          = 1'b0;
    daddr         = '0;
    dstore        = '0;
    fill_en       = 1'b0;
    fill_wsel     = 1'b0;
    inval_en      = 1'b0;

    case (state)
      IDLE: begin
        if (req && !hit) begin
          state_nxt = need_wb ? WRITEBACK0 : FILL0; // victim decides the path
        end else if (!req && halt) begin
          state_nxt     = FLUSH_SCAN;
          flush_idx_nxt = '0;
          flush_way_nxt = '0;
        end
      end

      WRITEBACK0: begin
        dWEN   = 1'b1;
        daddr  = {blk_tag, wb_idx, 1'b0, 2'b00};
        dstore = blk_data0;
        if (!dwait) begin
          state_nxt = WRITEBACK1;
        end
      end

      WRITEBACK1: begin
        dWEN   = 1'b1;
        daddr  = {blk_tag, wb_idx, 1'b1, 2'b00};
        dstore = blk_data1;
        if (!dwait) begin
          state_nxt = FILL0;
        end
      end

      FILL0: begin
        dREN    = 1'b1;
        daddr   = {req_tag, req_idx, 1'b0, 2'b00};
        fill_en = !dwait; // word captured as it completes
        if (!dwait) begin
          state_nxt = FILL1;
        end
      end

      FILL1: begin
        dREN      = 1'b1;
        daddr     = {req_tag, req_idx, 1'b1, 2'b00};
        fill_en   = !dwait;
        fill_wsel = 1'b1;
        if (!dwait) begin
          state_nxt = IDLE; // held request hits next cycle
        end
      end

      FLUSH_SCAN: begin
        if (need_wb) begin
          state_nxt = FLUSH_WB0;
        end else begin
          inval_en = 1'b1;  // clean or empty, drop it now
        end
      end

      FLUSH_WB0: begin
        dWEN   = 1'b1;
        daddr  = {blk_tag, wb_idx, 1'b0, 2'b00};
        dstore = blk_data0;
        if (!dwait) begin
          state_nxt = FLUSH_WB1;
        end
      end

      FLUSH_WB1: begin
        dWEN   = 1'b1;
        daddr  = {blk_tag, wb_idx, 1'b1, 2'b00};
        dstore = blk_data1;
        if (!dwait) begin
          inval_en = 1'b1;
        end
      end

      FLUSHED: begin
        state_nxt = FLUSHED;
      end

      default: begin
        state_nxt = IDLE;
      end
    endcase

    // each invalidated block moves the flush walk on
    if (inval_en) begin
      if (last_blk) begin
        state_nxt = FLUSHED;
      end else begin
        state_nxt     = FLUSH_SCAN;
        flush_idx_nxt = step_idx;
        flush_way_nxt = step_way;
      end
    end
  end

endmodule

// ==== design/dcache_params.svh ====
// geometry and address layout constants of the data cache
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// data word and byte address width
`define DCACHE_WORD_W 32

// two ways of eight sets each
`define DCACHE_SETS 8
`define DCACHE_IDX_W 3

// address layout, tag in bits 31..6
`define DCACHE_TAG_W 26
`define DCACHE_IDX_LSB 3  // set index in bits 5..3
`define DCACHE_WSEL_BIT 2 // word within a two-word block

// bits 1..0 are the byte offset and are ignored

`endif

// ==== design/dcache_pkg.sv ====
// data cache vector typedefs and controller state enum
package dcache_pkg;

  typedef logic [31:0] word_t;    // data word or byte address
  typedef logic [25:0] tag_t;     // block tag
  typedef logic [2:0]  set_idx_t; // set number
  typedef logic        way_t;     // way 0 or way 1
  typedef logic        word_sel_t; // word within a block

  // controller states
  typedef enum logic [3:0] {
    IDLE,
    WRITEBACK0,  // dirty victim, first word
    WRITEBACK1,
    FILL0,       // block fill from memory
    FILL1,
    FLUSH_SCAN,  // one block per cycle unless dirty
    FLUSH_WB0,
    FLUSH_WB1,
    FLUSHED      // terminal until reset
  } cache_state_t;

endpackage

// ==== design/dcache_store.sv ====
// data cache tag, data, valid, dirty and lru arrays with hit and victim logic
`include "dcache_params.svh"

module dcache_store (
  input  logic                  CLK,
  input  logic                  nRST,
  // lookup from the datapath address
  input  dcache_pkg::tag_t      req_tag,
  input  dcache_pkg::set_idx_t  req_idx,
  input  dcache_pkg::word_sel_t req_wsel,
  // flush walk selection
  input  logic                  flush_mode,
  input  dcache_pkg::set_idx_t  flush_idx,
  input  dcache_pkg::way_t      flush_way,
  // update strobes from the controller
  input  logic                  fill_en,
  input  logic                  fill_wsel,
  input  logic                  store_en,
  input  logic                  touch_en,
  input  logic                  inval_en,
  input  dcache_pkg::word_t     fill_data,
  input  dcache_pkg::word_t     store_data,
  // lookup results
  output logic                  hit,
  output dcache_pkg::way_t      hit_way,
  output dcache_pkg::word_t     hit_word,
  output dcache_pkg::way_t      victim_way,
  // selected block, victim or flush target
  output logic                  blk_valid,
  output logic                  blk_dirty,
  output dcache_pkg::tag_t      blk_tag,
  output dcache_pkg::word_t     blk_data0,
  output dcache_pkg::word_t     blk_data1
);
  import dcache_pkg::*;

  // storage, indexed [way][set]
  tag_t  tag_q  [2][`DCACHE_SETS];
  word_t data_q [2][`DCACHE_SETS][2]; // last index is the word in the block

  logic [`DCACHE_SETS-1:0] valid_q [2];
  logic [`DCACHE_SETS-1:0] dirty_q [2];
  logic [`DCACHE_SETS-1:0] lru_q;   // points at the least recently used way

  logic     match0;
  logic     match1;
  set_idx_t sel_idx;
  way_t     sel_way;

  // tag compare on both ways of the requested set
  assign match0 = valid_q[0][req_idx] && (tag_q[0][req_idx] == req_tag);
  assign match1 = valid_q[1][req_idx] && (tag_q[1][req_idx] == req_tag);

  assign hit        = match0 | match1;
  assign hit_way    = match1;
  assign hit_word   = data_q[hit_way][req_idx][req_wsel];
  assign victim_way = lru_q[req_idx];

  // flush overrides the victim selection
  assign sel_idx = flush_mode ? flush_idx : req_idx;
  assign sel_way = flush_mode ? flush_way : victim_way;

  assign blk_valid = valid_q[sel_way][sel_idx];
  assign blk_dirty = dirty_q[sel_way][sel_idx];
  assign blk_tag   = tag_q[sel_way][sel_idx];
  assign blk_data0 = data_q[sel_way][sel_idx][0];
  assign blk_data1 = data_q[sel_way][sel_idx][1];

  // payload arrays
  always_ff @(posedge CLK) begin
    if (fill_en) begin
      data_q[victim_way][req_idx][fill_wsel] <= fill_data;
      if (fill_wsel) begin
        tag_q[victim_way][req_idx] <= req_tag; // tag lands with the last word
      end
    end
    if (store_en) begin
      data_q[hit_way][req_idx][req_wsel] <= store_data;
    end
  end

  // block state and replacement bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      dirty_q[0] <= '0;
      dirty_q[1] <= '0;
      lru_q      <= '0;
    end else begin
      if (fill_en && fill_wsel) begin
        valid_q[victim_way][req_idx] <= 1'b1;
        dirty_q[victim_way][req_idx] <= 1'b0; // clean copy of memory
      end
      if (store_en) begin
        dirty_q[hit_way][req_idx] <= 1'b1;
      end
      if (inval_en) begin
        valid_q[sel_way][sel_idx] <= 1'b0;
        dirty_q[sel_way][sel_idx] <= 1'b0;
      end
      if (touch_en) begin
        lru_q[req_idx] <= ~hit_way; // other way becomes the victim
      end
    end
  end

endmodule

// ==== dv/dcache_tests.svh ====
// directed data cache tests for read miss, write hit, lru eviction, stalls and flush

  // cold read fills the block and the next word hits
  task automatic read_miss_fill();
    word_t a;
    word_t rd;
    a = 32'h0000_1008;
    cache_access(1'b0, a, '0, rd);
    check_word("dmemload", rd, fill_word(a));
    check_word("read count", word_t'(log_addr.size()), 32'd2);
    check_word("fill address 0", log_addr[0], 32'h0000_1008);
    check_word("fill address 1", log_addr[1], 32'h0000_100c);
    check_bit("fill is a read", log_we[0] | log_we[1], 1'b0);
    cache_access(1'b0, a + 32'd4, '0, rd);
    check_word("accesses on read hit", word_t'(log_addr.size()), 32'd0);
    check_word("dmemload", rd, fill_word(a + 32'd4));
  endtask

  task automatic write_hit_readback();
    word_t a;
    word_t old;
    word_t rd;
    a   = 32'h0000_100c;
    old = mem_read(a);
    cache_access(1'b1, a, 32'hcafe_0001, rd);
    check_word("accesses on write hit", word_t'(log_addr.size()), 32'd0);
    cache_access(1'b0, a, '0, rd);
    check_word("dmemload", rd, 32'hcafe_0001);
    check_word("memory after write hit", mem_read(a), old); // write-back keeps memory stale
  endtask

  // three blocks in set 5 and x1 ends up least recently used
  task automatic lru_eviction();
    word_t x0;
    word_t x1;
    word_t x2;
    word_t rd;
    x0 = 32'h0000_2028;
    x1 = 32'h0000_3028;
    x2 = 32'h0000_5028;
    cache_access(1'b1, x0, 32'h1111_0000, rd); // way 0
    cache_access(1'b1, x1, 32'h2222_0000, rd); // way 1
    cache_access(1'b0, x0, '0, rd);
    cache_access(1'b0, x2, '0, rd);
    check_word("evict access count", word_t'(log_addr.size()), 32'd4);
    check_bit("write-back 0", log_we[0], 1'b1);
    check_bit("write-back 1", log_we[1], 1'b1);
    check_word("write-back address 0", log_addr[0], x1);
    check_word("write-back address 1", log_addr[1], x1 + 32'd4);
    check_word("write-back data 0", log_data[0], 32'h2222_0000);
    check_word("write-back data 1", log_data[1], fill_word(x1 + 32'd4));
    check_word("fill address 0", log_addr[2], x2);
    check_word("fill address 1", log_addr[3], x2 + 32'd4);
    check_word("memory at victim", mem_read(x1), 32'h2222_0000);
    cache_access(1'b0, x0, '0, rd);
    check_word("x0 still resident", word_t'(log_addr.size()), 32'd0);
  endtask

  // four tags over four sets so misses and evictions mix with hits
  task automatic stall_mix();
    word_t a;
    word_t d;
    word_t rd;
    logic  we;
    stall_cycles = 0;
    for (int i = 0; i < 48; i++) begin
      a  = 32'h0000_4000 | (word_t'(rand_bits(2)) << 6);
      a  = a | (word_t'(rand_bits(2)) << 3);
      a  = a | (word_t'(rand_bit()) << 2);
      we = rand_bit();
      d  = word_t'(rand_bits(16)) << 16;
      d  = d | word_t'(rand_bits(16));
      cache_access(we, a, d, rd);
    end
    check_bit("stall cycles seen", stall_cycles > 0, 1'b1);
  endtask

  task automatic halt_flush();
    int   ndirty;
    int   n;
    int   nlog;
    logic seen [word_t];
    logic owned;
    ndirty = 0;
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      for (int w = 0; w < 2; w++) begin
        if (ref_valid[w][s] && ref_dirty[w][s]) begin
          ndirty++;
        end
      end
    end
    clear_log();
    halt = 1'b1;
    n = 0;
    @(negedge CLK);
    while (!flushed) begin
      n++;
      if (n == TIMEOUT) begin
        $display("flushed did not rise within %0d cycles of halt", TIMEOUT);
        abort_run();
      end
      @(negedge CLK);
    end
    check_word("flush write count", word_t'(log_addr.size()), word_t'(2 * ndirty));
    foreach (log_addr[i]) begin
      check_bit("flush access is write", log_we[i], 1'b1);
      check_bit("address written twice", seen.exists(log_addr[i]), 1'b0);
      seen[log_addr[i]] = 1'b1;
      owned = 1'b0;
      for (int w = 0; w < 2; w++) begin
        if (ref_valid[w][log_addr[i][5:3]] && ref_dirty[w][log_addr[i][5:3]] &&
            ref_tag[w][log_addr[i][5:3]] == log_addr[i][31:6]) begin
          owned = 1'b1;
        end
      end
      check_bit("flush write hits a dirty block", owned, 1'b1);
    end
    foreach (ref_mem[a]) begin
      check_word("memory after flush", mem_read(a), ref_mem[a]);
    end
    nlog = log_addr.size();
    repeat (20) begin
      @(negedge CLK);
      check_bit("flushed", flushed, 1'b1);
      check_bit("dREN after flush", dREN, 1'b0);
      check_bit("dWEN after flush", dWEN, 1'b0);
    end
    check_word("accesses after flushed", word_t'(log_addr.size()), word_t'(nlog));
  endtask

// ==== dv/dcache_tb.sv ====
// data cache testbench top with clock, reset, memory model, reference model and checks
`include "dcache_params.svh"

module dcache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import dcache_pkg::*;

  localparam int TIMEOUT = 400; // cycles allowed for any single wait

  logic  CLK = 1'b0;
  logic  nRST;
  logic  dmemREN, dmemWEN, halt;
  word_t dmemaddr, dmemstore, dmemload;
  logic  dhit, flushed;
  logic  dREN, dWEN;
  logic  dwait = 1'b0;
  word_t daddr, dstore;
  word_t dload = '0;

  // memory model and its access log
  word_t mem [word_t];
  word_t log_addr [$];
  word_t log_data [$];
  logic  log_we [$];
  logic  mem_busy = 1'b0;
  int    wait_left;
  int    stall_cycles = 0;
  logic  held_ren, held_wen;
  word_t held_addr, held_store;

  // reference model indexed by way then set
  tag_t  ref_tag [2][`DCACHE_SETS];
  logic  ref_valid [2][`DCACHE_SETS];
  logic  ref_dirty [2][`DCACHE_SETS];
  logic  ref_lru [`DCACHE_SETS];
  word_t ref_mem [word_t]; // latest value of every written word

  logic [15:0] lfsr = 16'd50;

  always #2 CLK = ~CLK;

  dcache uut (
    .CLK, .nRST, .dmemREN, .dmemWEN, .halt, .dmemaddr, .dmemstore,
    .dhit, .flushed, .dmemload,
    .dREN, .dWEN, .daddr, .dstore, .dwait, .dload
  );

  function automatic logic rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hb400; // galois taps 16,14,13,11
    end
    return out;
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  // contents of a word that was never written
  function automatic word_t fill_word(word_t a);
    return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic word_t mem_read(word_t a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  function automatic word_t ref_read(word_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0.1f ns: %s got %h expected %h", $realtime, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL at %0.1f ns: %s got %b expected %b", $realtime, name, got, exp);
      abort_run();
    end
  endtask

  task automatic clear_log();
    log_addr.delete();
    log_data.delete();
    log_we.delete();
  endtask

  // memory port with random stall of 0 to 3 cycles per word
  always @(posedge CLK) begin
    #1;
    if ((dREN || dWEN) && !mem_busy) begin
      mem_busy   = 1'b1;
      wait_left  = rand_bits(2);
      held_ren   = dREN;
      held_wen   = dWEN;
      held_addr  = daddr;
      held_store = dstore;
    end
    if (mem_busy) begin
      check_bit("dREN", dREN, held_ren); // access frozen while stalled
      check_bit("dWEN", dWEN, held_wen);
      check_word("daddr", daddr, held_addr);
      check_word("dstore", dstore, held_store);
      if (wait_left > 0) begin
        dwait        = 1'b1;
        wait_left    = wait_left - 1;
        stall_cycles = stall_cycles + 1;
      end else begin
        dwait    = 1'b0;
        mem_busy = 1'b0;
        log_addr.push_back(daddr);
        log_we.push_back(dWEN);
        if (dWEN) begin
          mem[daddr] = dstore;
          log_data.push_back(dstore);
        end else begin
          dload = mem_read(daddr);
          log_data.push_back(dload);
        end
      end
    end
  end

  task automatic apply_reset();
    nRST      = 1'b0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    halt      = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      ref_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
      end
    end
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    check_bit("dhit", dhit, 1'b0);
    check_bit("dREN", dREN, 1'b0);
    check_bit("dWEN", dWEN, 1'b0);
    check_bit("flushed", flushed, 1'b0);
    @(posedge CLK);
    #1;
  endtask

  // one datapath access checked against the reference model
  task automatic cache_access(logic we, word_t addr, word_t wdata, output word_t rdata);
    tag_t     tag;
    set_idx_t idx;
    way_t     way;
    logic     hit_exp;
    int       nwb;
    int       nexp;
    int       n;
    word_t    base;
    word_t    vbase;
    tag     = addr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
    idx     = addr[`DCACHE_IDX_LSB +: `DCACHE_IDX_W];
    base    = {addr[31:3], 3'b000};
    hit_exp = 1'b0;
    way     = ref_lru[idx];
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
        hit_exp = 1'b1;
        way     = way_t'(w);
      end
    end
    nwb   = (!hit_exp && ref_valid[way][idx] && ref_dirty[way][idx]) ? 2 : 0;
    nexp  = hit_exp ? 0 : nwb + 2;
    vbase = {ref_tag[way][idx], idx, 3'b000};
    clear_log();
    dmemREN   = !we;
    dmemWEN   = we;
    dmemaddr  = addr;
    dmemstore = wdata;
    n = 0;
    @(negedge CLK);
    while (!dhit) begin
      n++;
      if (n == TIMEOUT) begin
        $display("no dhit for access to %h within %0d cycles", addr, TIMEOUT);
        abort_run();
      end
      @(negedge CLK);
    end
    if (hit_exp) begin
      check_word("cycles before dhit on a hit", word_t'(n), 32'd0);
    end
    rdata = dmemload;
    if (!we) begin
      check_word("dmemload", dmemload, ref_read(addr));
    end
    check_word("memory access count", word_t'(log_addr.size()), word_t'(nexp));
    for (int i = 0; i < nexp; i++) begin
      check_bit("memory write", log_we[i], logic'(i < nwb));
      if (i < nwb) begin
        check_word("write-back address", log_addr[i], vbase + word_t'(4 * i));
        check_word("write-back data", log_data[i], ref_read(vbase + word_t'(4 * i)));
      end else begin
        check_word("fill address", log_addr[i], base + word_t'(4 * (i - nwb)));
      end
    end
    if (!hit_exp) begin
      ref_tag[way][idx]   = tag;
      ref_valid[way][idx] = 1'b1;
      ref_dirty[way][idx] = 1'b0;
    end
    ref_lru[idx] = ~way;
    if (we) begin
      ref_dirty[way][idx]           = 1'b1;
      ref_mem[{addr[31:2], 2'b00}] = wdata;
    end
    @(posedge CLK);
    #1;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
  endtask

  `include "dcache_tests.svh"

  initial begin
    apply_reset();
    read_miss_fill();
    write_hit_readback();
    lru_eviction();
    stall_mix();
    halt_flush();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+design
+incdir+dv
design/dcache_pkg.sv
design/dcache_store.sv
design/dcache_ctrl.sv
design/dcache.sv
dv/dcache_tb.sv
